//--- common/bottom_pkg.sv
// Lower datapath shared types
package bottom_pkg;

	// Command operation, in the top nibble of every command word
	typedef enum logic [3:0] {
		OP_LOAD_REG  = 4'd0,	// Immediate into a byte register
		OP_READ_REG  = 4'd1,	// Byte register onto rd_data
		OP_INC_PAIR  = 4'd2,	// Pair + 1, shown on addr
		OP_DEC_PAIR  = 4'd3,	// Pair - 1, shown on addr
		OP_WRITE_MEM = 4'd4,	// A to the pair address
		OP_READ_MEM  = 4'd5,	// Read from the pair address
		OP_EI        = 4'd6,	// Set master interrupt enable
		OP_DISPATCH  = 4'd7	// Take the winning interrupt
	} op_t;

	// Byte register select, value 7 is reserved
	typedef enum logic [2:0] {
		REG_A = 3'd0,
		REG_B = 3'd1,
		REG_C = 3'd2,
		REG_D = 3'd3,
		REG_E = 3'd4,
		REG_H = 3'd5,
		REG_L = 3'd6
	} reg_sel_t;

	// Register pair select for the 16-bit paths
	typedef enum logic [1:0] {
		PAIR_BC = 2'd0,
		PAIR_DE = 2'd1,
		PAIR_HL = 2'd2,
		PAIR_PC = 2'd3
	} pair_sel_t;

	// One command word, read as a byte command or as a pair command
	typedef union packed {
		struct packed {
			op_t        op;	// [15:12]
			reg_sel_t   rsel;	// [11:9]
			logic       pad;	// [8]
			logic [7:0] imm;	// [7:0]
		} reg_view;
		struct packed {
			op_t        op;	// [15:12]
			pair_sel_t  psel;	// [11:10]
			logic [9:0] pad;	// [9:0]
		} pair_view;
	} cmd_word_u;

	// Memory map and vector layout
	localparam logic [15:0] IE_ADDR     = 16'hFFFF;	// Interrupt enable register
	localparam logic [7:0]  OPEN_BUS    = 8'hFF;	// Undriven data bus reads high
	localparam logic [15:0] VEC_SPACING = 16'd8;	// Bytes between vectors

endpackage

//--- hw/incdec16.sv
// 16-bit increment and decrement unit
`timescale 1ns/10ps

module incdec16 (
	input  logic [15:0] val,
	input  logic        dec,
	output logic [15:0] res
);

	logic [15:0] match;	// Bits that propagate the carry
	logic [7:0]  tog_lo;
	logic [7:0]  tog_hi;
	logic        lo_cout;	// Low half rolls over

	// Toggle enables for one 8-bit half of the chain
	function automatic logic [7:0] half_toggles(input logic [7:0] m, input logic cin);
		logic [7:0] t;
		t[0] = cin;
		for (int i = 1; i < 8; i++) begin
			t[i] = t[i-1] & m[i-1];
		end
		return t;
	endfunction

	// Increment passes on ones, decrement on zeros
	assign match = dec ? ~val : val;

	assign tog_lo  = half_toggles(match[7:0], 1'b1);
	assign lo_cout = tog_lo[7] & match[7];
	assign tog_hi  = half_toggles(match[15:8], lo_cout);

	assign res = val ^ {tog_hi, tog_lo};	// Wraps at both ends

endmodule

//--- hw/reg_file.sv
// General registers and program counter
`timescale 1ns/10ps

module reg_file import bottom_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        rf_we,
	input  reg_sel_t    rf_wsel,
	input  logic [7:0]  rf_wdata,
	input  reg_sel_t    rf_rsel,
	input  pair_sel_t   rf_psel,
	input  logic        rf_pwe,
	input  logic [15:0] rf_pwdata,
	output logic [7:0]  rf_rdata,
	output logic [15:0] rf_pair
);

	logic [7:0]  a, b, c, d, e, h, l;
	logic [15:0] pc;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			a  <= '0;
			b  <= '0;
			c  <= '0;
			d  <= '0;
			e  <= '0;
			h  <= '0;
			l  <= '0;
			pc <= '0;
		end else begin
			if (rf_we) begin
				case (rf_wsel)
					REG_A: a <= rf_wdata;
					REG_B: b <= rf_wdata;
					REG_C: c <= rf_wdata;
					REG_D: d <= rf_wdata;
					REG_E: e <= rf_wdata;
					REG_H: h <= rf_wdata;
					REG_L: l <= rf_wdata;
					default: ;	// Reserved select writes nothing
				endcase
			end
			if (rf_pwe) begin
				case (rf_psel)
					PAIR_BC: {b, c} <= rf_pwdata;	// High byte in B
					PAIR_DE: {d, e} <= rf_pwdata;
					PAIR_HL: {h, l} <= rf_pwdata;
					PAIR_PC: pc <= rf_pwdata;
				endcase
			end
		end
	end

	always_comb begin
		case (rf_rsel)
			REG_A: rf_rdata = a;
			REG_B: rf_rdata = b;
			REG_C: rf_rdata = c;
			REG_D: rf_rdata = d;
			REG_E: rf_rdata = e;
			REG_H: rf_rdata = h;
			REG_L: rf_rdata = l;
			default: rf_rdata = '0;
		endcase
	end

	always_comb begin
		case (rf_psel)
			PAIR_BC: rf_pair = {b, c};
			PAIR_DE: rf_pair = {d, e};
			PAIR_HL: rf_pair = {h, l};
			default: rf_pair = pc;
		endcase
	end

	// Sequencer issues at most one register write per transaction
	a_one_write: assert property (@(posedge clk) disable iff (!arst_n) !(rf_we && rf_pwe));

endmodule

//--- hw/cmd_sequencer.sv
// Command handshake and execution
`timescale 1ns/10ps

module cmd_sequencer import bottom_pkg::*; #(
	parameter int N_IRQ = 8
) (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             cmd_req,
	input  cmd_word_u        cmd_word,
	input  logic [7:0]       rf_rdata,
	input  logic [15:0]      rf_pair,
	input  logic [15:0]      incdec_res,
	input  logic [N_IRQ-1:0] ie_q,
	input  logic             irq_pending,
	input  logic [15:0]      vector,
	output logic             cmd_ack,
	output logic [7:0]       rd_data,
	output logic [15:0]      addr,
	output logic             rf_we,
	output reg_sel_t         rf_wsel,
	output logic [7:0]       rf_wdata,
	output reg_sel_t         rf_rsel,
	output pair_sel_t        rf_psel,
	output logic             rf_pwe,
	output logic [15:0]      rf_pwdata,
	output logic             dec,
	output logic             ie_we,
	output logic [7:0]       ie_wdata,
	output logic             ime_set,
	output logic             dispatch
);

	op_t        op;
	reg_sel_t   rsel;
	pair_sel_t  psel;
	logic       start;	// Execute strobe, one per transaction
	logic       is_ie;
	logic [7:0] ie_byte;

	assign op    = cmd_word.reg_view.op;
	assign rsel  = cmd_word.reg_view.rsel;
	assign psel  = cmd_word.pair_view.psel;
	assign start = cmd_req & ~cmd_ack;
	assign is_ie = (rf_pair == IE_ADDR);

	always_comb begin
		ie_byte = '0;
		ie_byte[N_IRQ-1:0] = ie_q;	// IE reads back zero-extended
	end

	// Byte ports, A is the source for memory writes
	assign rf_we    = start & (op == OP_LOAD_REG);
	assign rf_wsel  = rsel;
	assign rf_wdata = cmd_word.reg_view.imm;
	assign rf_rsel  = (op == OP_WRITE_MEM) ? REG_A : rsel;

	// Pair port, dispatch always targets PC
	assign rf_psel   = (op == OP_DISPATCH) ? PAIR_PC : psel;
	assign dec       = (op == OP_DEC_PAIR);
	assign dispatch  = start & (op == OP_DISPATCH) & irq_pending;
	assign rf_pwe    = (start & (op == OP_INC_PAIR || op == OP_DEC_PAIR)) | dispatch;
	assign rf_pwdata = (op == OP_DISPATCH) ? vector : incdec_res;

	assign ie_we    = start & (op == OP_WRITE_MEM) & is_ie;
	assign ie_wdata = rf_rdata;
	assign ime_set  = start & (op == OP_EI);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cmd_ack <= 1'b0;
			rd_data <= '0;
			addr    <= '0;
		end else if (start) begin
			cmd_ack <= 1'b1;
			case (op)
				OP_READ_REG: rd_data <= rf_rdata;
				OP_INC_PAIR, OP_DEC_PAIR: addr <= incdec_res;
				OP_WRITE_MEM: addr <= rf_pair;
				OP_READ_MEM: begin
					addr    <= rf_pair;
					rd_data <= is_ie ? ie_byte : OPEN_BUS;	// Only IE is mapped
				end
				default: ;	// Other ops touch no payload
			endcase
		end else if (!cmd_req) begin
			cmd_ack <= 1'b0;	// Return to idle phase
		end
	end

	// Requester must hold the word for the whole request phase
	a_word_stable: assert property (@(posedge clk) disable iff (!arst_n)
		cmd_req && $past(cmd_req) |-> $stable(cmd_word));

	// Byte commands never carry the reserved select into execution
	a_no_reserved: assert property (@(posedge clk) disable iff (!arst_n)
		start && (op == OP_LOAD_REG || op == OP_READ_REG) |-> rsel != 3'd7);

endmodule

//--- irq/irq_enable_reg.sv
// Interrupt enable and master enable
`timescale 1ns/10ps

module irq_enable_reg #(
	parameter int N_IRQ = 8
) (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             ie_we,
	input  logic [7:0]       ie_wdata,
	input  logic             ime_set,
	input  logic             dispatch,
	output logic [N_IRQ-1:0] ie_q,
	output logic             ime
);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ie_q <= '0;
			ime  <= 1'b0;
		end else begin
			if (ie_we) begin
				ie_q <= ie_wdata[N_IRQ-1:0];	// Upper bits not implemented
			end
			if (dispatch) begin
				ime <= 1'b0;	// Taking an interrupt masks the rest
			end else if (ime_set) begin
				ime <= 1'b1;
			end
		end
	end

endmodule

//--- irq/irq_arbiter.sv
// Interrupt flags and priority arbiter
`timescale 1ns/10ps

module irq_arbiter import bottom_pkg::*; #(
	parameter int          N_IRQ       = 8,
	parameter logic [15:0] VECTOR_BASE = 16'h0040
) (
	input  logic             clk,
	input  logic             arst_n,
	input  logic [N_IRQ-1:0] irq_trig,
	input  logic [N_IRQ-1:0] ie_q,
	input  logic             ime,
	input  logic             dispatch,
	output logic             irq_pending,
	output logic [15:0]      vector,
	output logic [N_IRQ-1:0] irq_ack
);

	logic [N_IRQ-1:0] if_q;	// Sticky request flags
	logic [N_IRQ-1:0] pend;
	logic [N_IRQ-1:0] grant;	// One-hot winner
	logic [2:0]       win_idx;

	assign pend  = if_q & ie_q;
	assign grant = pend & (~pend + 1'b1);	// Isolate lowest set bit

	always_comb begin
		win_idx = '0;
		for (int i = N_IRQ - 1; i >= 0; i--) begin
			if (pend[i]) begin
				win_idx = 3'(i);
			end
		end
	end

	assign irq_pending = ime & (|pend);
	assign vector      = VECTOR_BASE + VEC_SPACING * 16'(win_idx);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			if_q    <= '0;
			irq_ack <= '0;
		end else begin
			// A new trigger on the same edge keeps its flag set
			if_q    <= (if_q & ~(dispatch ? grant : '0)) | irq_trig;
			irq_ack <= dispatch ? grant : '0;	// Single-cycle pulse
		end
	end

	// Acknowledge is one-hot and names the line whose vector was taken
	a_ack_onehot: assert property (@(posedge clk) disable iff (!arst_n)
		dispatch |=> irq_ack == (N_IRQ'(1) << $past(win_idx)));

endmodule

//--- hw/cpu_bottom.sv
// CPU lower datapath top level
`timescale 1ns/10ps

module cpu_bottom import bottom_pkg::*; #(
	parameter int          N_IRQ       = 8,
	parameter logic [15:0] VECTOR_BASE = 16'h0040
) (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             cmd_req,
	input  cmd_word_u        cmd_word,
	input  logic [N_IRQ-1:0] irq_trig,
	output logic             cmd_ack,
	output logic [7:0]       rd_data,
	output logic [15:0]      addr,
	output logic             irq_pending,
	output logic [N_IRQ-1:0] irq_ack
);

	logic             rf_we;	// Byte write port
	reg_sel_t         rf_wsel;
	logic [7:0]       rf_wdata;
	reg_sel_t         rf_rsel;	// Byte read port
	logic [7:0]       rf_rdata;
	pair_sel_t        rf_psel;	// Pair port
	logic [15:0]      rf_pair;
	logic             rf_pwe;
	logic [15:0]      rf_pwdata;
	logic             dec;
	logic [15:0]      incdec_res;
	logic             ie_we;
	logic [7:0]       ie_wdata;
	logic             ime_set;
	logic             dispatch;
	logic [N_IRQ-1:0] ie_q;
	logic             ime;
	logic [15:0]      vector;

	cmd_sequencer #(.N_IRQ(N_IRQ)) seq_i (
		.clk(clk), .arst_n(arst_n),
		.cmd_req(cmd_req), .cmd_word(cmd_word), .cmd_ack(cmd_ack),
		.rd_data(rd_data), .addr(addr),
		.rf_we(rf_we), .rf_wsel(rf_wsel), .rf_wdata(rf_wdata),
		.rf_rsel(rf_rsel), .rf_rdata(rf_rdata),
		.rf_psel(rf_psel), .rf_pair(rf_pair),
		.rf_pwe(rf_pwe), .rf_pwdata(rf_pwdata),
		.dec(dec), .incdec_res(incdec_res),
		.ie_we(ie_we), .ie_wdata(ie_wdata), .ie_q(ie_q),
		.ime_set(ime_set), .dispatch(dispatch),
		.irq_pending(irq_pending), .vector(vector)
	);

	reg_file rf_i (
		.clk(clk), .arst_n(arst_n),
		.rf_we(rf_we), .rf_wsel(rf_wsel), .rf_wdata(rf_wdata),
		.rf_rsel(rf_rsel), .rf_rdata(rf_rdata),
		.rf_psel(rf_psel), .rf_pair(rf_pair),
		.rf_pwe(rf_pwe), .rf_pwdata(rf_pwdata)
	);

	incdec16 incdec_i (.val(rf_pair), .dec(dec), .res(incdec_res));

	irq_enable_reg #(.N_IRQ(N_IRQ)) ie_i (
		.clk(clk), .arst_n(arst_n),
		.ie_we(ie_we), .ie_wdata(ie_wdata),
		.ime_set(ime_set), .dispatch(dispatch),
		.ie_q(ie_q), .ime(ime)
	);

	irq_arbiter #(.N_IRQ(N_IRQ), .VECTOR_BASE(VECTOR_BASE)) arb_i (
		.clk(clk), .arst_n(arst_n),
		.irq_trig(irq_trig), .ie_q(ie_q), .ime(ime), .dispatch(dispatch),
		.irq_pending(irq_pending), .vector(vector), .irq_ack(irq_ack)
	);

endmodule

//--- sim/tb_cpu_bottom.sv
// CPU lower datapath testbench
`timescale 1ns/10ps

module tb_cpu_bottom import bottom_pkg::*; ();

	localparam int          N_IRQ       = 8;
	localparam logic [15:0] VECTOR_BASE = 16'h0040;
	localparam int          CLK_PERIOD  = 100;
	localparam int          RST_CYCLES  = 16;
	localparam int          N_CMDS      = 72;	// Commands issued over all tests

	logic             clk;
	logic             arst_n;
	logic             cmd_req;
	cmd_word_u        cmd_word;
	logic [N_IRQ-1:0] irq_trig;
	logic             cmd_ack;
	logic [7:0]       rd_data;
	logic [15:0]      addr;
	logic             irq_pending;
	logic [N_IRQ-1:0] irq_ack;

	logic             chk_rd;	// Expected response of the running command
	logic             chk_addr;
	logic [7:0]       exp_rd;
	logic [15:0]      exp_addr;
	logic [N_IRQ-1:0] exp_ack;
	logic             exp_pend;
	logic [7:0]       regs_m [7];	// Register model indexed like reg_sel_t
	logic [15:0]      pc_m;
	logic [N_IRQ-1:0] ie_m;
	logic [N_IRQ-1:0] if_m;
	logic             ime_m;
	logic [31:0]      rng;
	int               err_cnt;
	int               tests_ok;
	int               tests_bad;

	cpu_bottom #(.N_IRQ(N_IRQ), .VECTOR_BASE(VECTOR_BASE)) dut_i (
		.clk(clk), .arst_n(arst_n), .cmd_req(cmd_req), .cmd_word(cmd_word),
		.irq_trig(irq_trig), .cmd_ack(cmd_ack), .rd_data(rd_data), .addr(addr),
		.irq_pending(irq_pending), .irq_ack(irq_ack)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#((N_CMDS * 10 + RST_CYCLES) * CLK_PERIOD);
		$display("Watchdog expired before all tests completed");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	a_rd: assert property (@(posedge clk) disable iff (!arst_n)
		cmd_ack && chk_rd |-> rd_data == exp_rd)
		else begin
			$display("ERR t=%0t rd_data exp=%02h got=%02h", $time, $sampled(exp_rd),
				$sampled(rd_data));
			err_cnt++;
		end

	a_addr: assert property (@(posedge clk) disable iff (!arst_n)
		cmd_ack && chk_addr |-> addr == exp_addr)
		else begin
			$display("ERR t=%0t addr exp=%04h got=%04h", $time, $sampled(exp_addr),
				$sampled(addr));
			err_cnt++;
		end

	a_irq_ack: assert property (@(posedge clk) disable iff (!arst_n)
		cmd_ack |-> irq_ack == exp_ack)
		else begin
			$display("ERR t=%0t irq_ack exp=%02h got=%02h", $time, $sampled(exp_ack),
				$sampled(irq_ack));
			err_cnt++;
		end

	a_pend: assert property (@(posedge clk) disable iff (!arst_n)
		cmd_ack |-> irq_pending == exp_pend)
		else begin
			$display("ERR t=%0t irq_pending exp=%0b got=%0b", $time, $sampled(exp_pend),
				$sampled(irq_pending));
			err_cnt++;
		end

	// Handshake timing and the idle phase
	a_ack_quiet: assert property (@(posedge clk) disable iff (!arst_n)
		!cmd_ack |-> irq_ack == '0)
		else begin
			$display("irq_ack was set outside an acknowledged command");
			err_cnt++;
		end

	a_ack_release: assert property (@(posedge clk) disable iff (!arst_n)
		!cmd_req |=> !cmd_ack)
		else begin
			$display("cmd_ack stayed high after cmd_req was released");
			err_cnt++;
		end

	a_ack_delay: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(cmd_req) |=> cmd_ack)
		else begin
			$display("cmd_ack did not follow cmd_req after one cycle");
			err_cnt++;
		end

	a_ack_hold: assert property (@(posedge clk) disable iff (!arst_n)
		cmd_req && cmd_ack |=> cmd_ack)
		else begin
			$display("cmd_ack dropped while cmd_req was still held");
			err_cnt++;
		end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [15:0] pair_model(input pair_sel_t p);
		case (p)
			PAIR_BC: return {regs_m[1], regs_m[2]};
			PAIR_DE: return {regs_m[3], regs_m[4]};
			PAIR_HL: return {regs_m[5], regs_m[6]};
			default: return pc_m;
		endcase
	endfunction

	task automatic store_pair(input pair_sel_t p, input logic [15:0] v);
		case (p)
			PAIR_BC: {regs_m[1], regs_m[2]} = v;
			PAIR_DE: {regs_m[3], regs_m[4]} = v;
			PAIR_HL: {regs_m[5], regs_m[6]} = v;
			default: pc_m = v;
		endcase
	endtask

	// Four-phase transfer with the request held for extra cycles
	task automatic handshake(input cmd_word_u w, input int hold);
		int n;
		n = 0;
		exp_pend = ime_m & (|(if_m & ie_m));
		@(negedge clk);
		cmd_word = w;
		cmd_req  = 1'b1;
		do begin
			@(negedge clk);
			n++;
		end while (!cmd_ack && n < 8);
		if (!cmd_ack) begin
			$display("No cmd_ack for command word %04h", w);
			err_cnt++;
		end
		repeat (hold) @(negedge clk);
		cmd_req = 1'b0;
		while (cmd_ack) @(negedge clk);
	endtask

	// Updates the model and the expected response before the transfer
	task automatic run_cmd(input op_t op, input int sel, input logic [7:0] imm,
		input int hold = 0);
		cmd_word_u        w;
		logic [15:0]      pv;
		logic [15:0]      vec;
		logic [N_IRQ-1:0] pend;
		int               idx;
		if (op == OP_LOAD_REG || op == OP_READ_REG) begin
			w.reg_view.op   = op;
			w.reg_view.rsel = reg_sel_t'(sel[2:0]);
			w.reg_view.pad  = 1'b0;
			w.reg_view.imm  = imm;
		end else begin
			w.pair_view.op   = op;
			w.pair_view.psel = pair_sel_t'(sel[1:0]);
			w.pair_view.pad  = '0;
		end
		pv       = pair_model(pair_sel_t'(sel[1:0]));
		chk_rd   = 1'b0;
		chk_addr = 1'b0;
		exp_ack  = '0;
		case (op)
			OP_LOAD_REG: regs_m[sel] = imm;
			OP_READ_REG: begin
				chk_rd = 1'b1;
				exp_rd = regs_m[sel];
			end
			OP_INC_PAIR, OP_DEC_PAIR: begin
				pv = (op == OP_DEC_PAIR) ? pv - 16'd1 : pv + 16'd1;
				store_pair(pair_sel_t'(sel[1:0]), pv);
				chk_addr = 1'b1;
				exp_addr = pv;
			end
			OP_WRITE_MEM: begin
				chk_addr = 1'b1;
				exp_addr = pv;
				if (pv == IE_ADDR) ie_m = regs_m[0][N_IRQ-1:0];
			end
			OP_READ_MEM: begin
				chk_rd   = 1'b1;
				chk_addr = 1'b1;
				exp_addr = pv;
				exp_rd   = (pv == IE_ADDR) ? 8'(ie_m) : OPEN_BUS;
			end
			OP_EI: ime_m = 1'b1;
			OP_DISPATCH: begin
				pend = if_m & ie_m;
				if (ime_m && pend != '0) begin
					idx = 0;
					vec = VECTOR_BASE;
					while (!pend[idx]) begin	// Lowest line wins
						idx++;
						vec = vec + VEC_SPACING;
					end
					exp_ack[idx] = 1'b1;
					if_m[idx]    = 1'b0;
					ime_m        = 1'b0;
					pc_m         = vec;
				end
			end
			default: ;
		endcase
		handshake(w, hold);
	endtask

	task automatic raise_irq(input logic [N_IRQ-1:0] lines);
		@(negedge clk);
		irq_trig = lines;
		@(negedge clk);
		irq_trig = '0;
		if_m = if_m | lines;
	endtask

	task automatic expect_zero(input string name, input logic [15:0] val);
		assert (val == '0)
			else begin
				$display("ERR t=%0t %s exp=0000 got=%04h", $time, name, val);
				err_cnt++;
			end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		if (err_cnt == errs_before) begin
			tests_ok++;
			$display("Test %s: ok", name);
		end else begin
			tests_bad++;
			$display("Test %s: %0d errors", name, err_cnt - errs_before);
		end
	endtask

	initial begin
		int e0;
		arst_n   = 1'b0;
		cmd_req  = 1'b0;
		cmd_word = '0;
		irq_trig = '0;
		chk_rd   = 1'b0;
		chk_addr = 1'b0;
		exp_rd   = '0;
		exp_addr = '0;
		exp_ack  = '0;
		exp_pend = 1'b0;
		foreach (regs_m[i]) regs_m[i] = '0;
		pc_m      = '0;
		ie_m      = '0;
		if_m      = '0;
		ime_m     = 1'b0;
		rng       = 32'd17081;
		err_cnt   = 0;
		tests_ok  = 0;
		tests_bad = 0;
		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		e0 = err_cnt;
		expect_zero("cmd_ack", 16'(cmd_ack));
		expect_zero("irq_ack", 16'(irq_ack));
		expect_zero("irq_pending", 16'(irq_pending));
		expect_zero("rd_data", 16'(rd_data));
		expect_zero("addr", addr);
		run_cmd(OP_LOAD_REG, REG_B, 8'h12);
		run_cmd(OP_LOAD_REG, REG_C, 8'h34);
		run_cmd(OP_INC_PAIR, PAIR_BC, 8'h00, 5);	// Held request executes once
		run_cmd(OP_READ_REG, REG_C, 8'h00);
		run_cmd(OP_READ_REG, REG_B, 8'h00);
		finish_test("handshake", e0);

		e0 = err_cnt;
		for (int r = 0; r < 7; r++) begin
			rng = xorshift(rng);
			run_cmd(OP_LOAD_REG, r, rng[7:0]);
		end
		for (int r = 6; r >= 0; r--) run_cmd(OP_READ_REG, r, 8'h00);
		finish_test("register load and read", e0);

		e0 = err_cnt;
		run_cmd(OP_LOAD_REG, REG_B, 8'hFF);
		run_cmd(OP_LOAD_REG, REG_C, 8'hFF);
		run_cmd(OP_INC_PAIR, PAIR_BC, 8'h00);	// Wraps to zero
		run_cmd(OP_DEC_PAIR, PAIR_BC, 8'h00);
		run_cmd(OP_LOAD_REG, REG_D, 8'h00);
		run_cmd(OP_LOAD_REG, REG_E, 8'hFF);
		run_cmd(OP_INC_PAIR, PAIR_DE, 8'h00);	// Carry into the high byte
		run_cmd(OP_DEC_PAIR, PAIR_DE, 8'h00);
		run_cmd(OP_DEC_PAIR, PAIR_PC, 8'h00);	// PC still zero here
		run_cmd(OP_INC_PAIR, PAIR_PC, 8'h00);
		run_cmd(OP_INC_PAIR, PAIR_HL, 8'h00);
		run_cmd(OP_DEC_PAIR, PAIR_HL, 8'h00);
		for (int i = 0; i < 12; i++) begin
			rng = xorshift(rng);
			run_cmd(rng[8] ? OP_DEC_PAIR : OP_INC_PAIR, rng[1:0], 8'h00);
		end
		finish_test("pair increment and decrement", e0);

		e0 = err_cnt;
		rng = xorshift(rng);
		run_cmd(OP_LOAD_REG, REG_H, 8'hFF);
		run_cmd(OP_LOAD_REG, REG_L, 8'hFF);
		run_cmd(OP_LOAD_REG, REG_A, rng[7:0]);
		run_cmd(OP_WRITE_MEM, PAIR_HL, 8'h00);
		run_cmd(OP_READ_MEM, PAIR_HL, 8'h00);
		run_cmd(OP_LOAD_REG, REG_D, 8'hFF);
		run_cmd(OP_LOAD_REG, REG_E, 8'hFE);
		run_cmd(OP_WRITE_MEM, PAIR_DE, 8'h00);	// Unmapped so IE stays unchanged
		run_cmd(OP_READ_MEM, PAIR_DE, 8'h00);
		run_cmd(OP_READ_MEM, PAIR_BC, 8'h00);
		run_cmd(OP_READ_MEM, PAIR_HL, 8'h00);
		finish_test("memory map", e0);

		e0 = err_cnt;
		run_cmd(OP_LOAD_REG, REG_A, 8'hFB);	// Line 2 masked
		run_cmd(OP_WRITE_MEM, PAIR_HL, 8'h00);
		run_cmd(OP_DISPATCH, PAIR_PC, 8'h00);	// Nothing pending yet
		run_cmd(OP_INC_PAIR, PAIR_PC, 8'h00);
		raise_irq(N_IRQ'(8'b0010_0110));
		run_cmd(OP_EI, PAIR_PC, 8'h00);
		repeat (2) begin
			run_cmd(OP_DISPATCH, PAIR_PC, 8'h00);
			run_cmd(OP_INC_PAIR, PAIR_PC, 8'h00);	// Vector plus one
			run_cmd(OP_DISPATCH, PAIR_PC, 8'h00);	// Master enable now clear
			run_cmd(OP_EI, PAIR_PC, 8'h00);
		end
		run_cmd(OP_DISPATCH, PAIR_PC, 8'h00);
		run_cmd(OP_LOAD_REG, REG_A, 8'hFF);
		run_cmd(OP_WRITE_MEM, PAIR_HL, 8'h00);	// Unmasks line 2
		run_cmd(OP_DISPATCH, PAIR_PC, 8'h00);
		run_cmd(OP_INC_PAIR, PAIR_PC, 8'h00);
		finish_test("interrupt dispatch", e0);

		$display("%0d tests ok, %0d tests failed, %0d errors", tests_ok, tests_bad, err_cnt);
		if (err_cnt == 0 && tests_bad == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- src.f
common/bottom_pkg.sv
hw/incdec16.sv
hw/reg_file.sv
hw/cmd_sequencer.sv
irq/irq_enable_reg.sv
irq/irq_arbiter.sv
hw/cpu_bottom.sv
sim/tb_cpu_bottom.sv

//--- run.sh
#!/usr/bin/env bash
# Compile with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu_bottom \
	-f src.f -o sim_tb \
	&& ./obj_dir/sim_tb 2>&1 | tee sim.log \
	|| { echo "Build or run failed"; exit 1; }
grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log || exit 1
exit 0
